//--- flist.f
hdl/dpBusPkg.sv
hdl/aluPkg.sv
hdl/registerBank.sv
hdl/aluCore.sv
hdl/processorStatus.sv
hdl/cpuDatapath.sv
tb/cpuDatapath_sva.sv
tb/tbCpuDatapath.sv

//--- Bender.yml
package:
  name: cpuDatapath

sources:
  # packages first, then RTL bottom up
  - files:
      - hdl/dpBusPkg.sv
      - hdl/aluPkg.sv
      - hdl/registerBank.sv
      - hdl/aluCore.sv
      - hdl/processorStatus.sv
      - hdl/cpuDatapath.sv

  # testbench top tbCpuDatapath and bound assertions
  - target: test
    files:
      - tb/cpuDatapath_sva.sv
      - tb/tbCpuDatapath.sv

//--- tb/tbCpuDatapath.sv
//////////////////////////////
// testbench for the 6502 datapath
// reference model, directed tests, summary
//////////////////////////////
module tbCpuDatapath;
  timeunit 1ns;
  timeprecision 100ps;

  // about 500 single-cycle ops plus reset, so 2000 leaves wide margin
  localparam int maxCycles = 2000;

  logic             phi2;
  logic             arstN;
  logic             opStrobe;
  dpBusPkg::busSrcT opSrc;
  aluPkg::aluOpT    opAlu;
  dpBusPkg::regDstT opDst;
  dpBusPkg::byteT   dataIn;
  dpBusPkg::byteT   acc;
  dpBusPkg::byteT   xReg;
  dpBusPkg::byteT   yReg;
  aluPkg::statusT   status;

  // expected architectural state
  dpBusPkg::byteT expA;
  dpBusPkg::byteT expX;
  dpBusPkg::byteT expY;
  aluPkg::statusT expStatus;

  int cycleCount;
  int checkCount;
  int errorCount;
  int testErrors;
  int testCount;

  cpuDatapath dut_i (
    .phi2     (phi2),
    .arstN    (arstN),
    .opStrobe (opStrobe),
    .opSrc    (opSrc),
    .opAlu    (opAlu),
    .opDst    (opDst),
    .dataIn   (dataIn),
    .acc      (acc),
    .xReg     (xReg),
    .yReg     (yReg),
    .status   (status)
  );

  initial begin
    phi2 = 1'b0;
    forever #2 phi2 = ~phi2;
  end

  always @(posedge phi2) begin
    cycleCount++;
    if (cycleCount >= maxCycles) begin
      $display("run stopped: reached the %0d cycle limit before the tests ended", maxCycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic dpBusPkg::byteT randomByte();
    return dpBusPkg::byteT'($urandom_range(0, 255));
  endfunction

  task automatic checkByte(input string testName, input string what,
                           input dpBusPkg::byteT expected, input dpBusPkg::byteT actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      testErrors++;
      $display("ERROR %s: %s expected %02h actual %02h", testName, what, expected, actual);
    end
  endtask

  task automatic checkStatus(input string testName,
                             input aluPkg::statusT expected, input aluPkg::statusT actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      testErrors++;
      $display("ERROR %s: status expected %02h actual %02h", testName, expected, actual);
    end
  endtask

  task automatic checkAll(input string testName);
    checkByte(testName, "acc", expA, acc);
    checkByte(testName, "xReg", expX, xReg);
    checkByte(testName, "yReg", expY, yReg);
    checkStatus(testName, expStatus, status);
  endtask

  // applies one micro-op to the expected state
  task automatic modelOp(input dpBusPkg::busSrcT src, input aluPkg::aluOpT alu,
                         input dpBusPkg::regDstT dst, input dpBusPkg::byteT b);
    dpBusPkg::byteT a;
    dpBusPkg::byteT r;
    int             wideSum;
    int             signedSum;
    logic           hasResult;
    logic           writesReg;
    case (src)
      dpBusPkg::srcAcc: a = expA;
      dpBusPkg::srcX:   a = expX;
      dpBusPkg::srcY:   a = expY;
      default:          a = b;
    endcase
    r = a;
    hasResult = 1'b1;
    writesReg = 1'b1;
    case (alu)
      aluPkg::aluPass: r = a;
      aluPkg::aluAdc: begin
        wideSum   = int'(a) + int'(b) + int'(expStatus[aluPkg::statusC]);
        signedSum = int'($signed(a)) + int'($signed(b)) + int'(expStatus[aluPkg::statusC]);
        r = wideSum[7:0];
        expStatus[aluPkg::statusC] = (wideSum > 255);
        expStatus[aluPkg::statusV] = (signedSum > 127) || (signedSum < -128);
      end
      aluPkg::aluAnd: r = a & b;
      aluPkg::aluEor: r = a ^ b;
      aluPkg::aluOr:  r = a | b;
      aluPkg::aluLsr: begin
        r = a >> 1;
        expStatus[aluPkg::statusC] = a[0];
      end
      aluPkg::aluCmp: begin
        r = dpBusPkg::byteT'(int'(a) - int'(b));
        expStatus[aluPkg::statusC] = (a >= b);
        writesReg = 1'b0;
      end
      default: begin
        hasResult = 1'b0;
        writesReg = 1'b0;
        case (alu)
          aluPkg::aluSetC: expStatus[aluPkg::statusC] = 1'b1;
          aluPkg::aluClrC: expStatus[aluPkg::statusC] = 1'b0;
          aluPkg::aluSetI: expStatus[aluPkg::statusI] = 1'b1;
          aluPkg::aluClrI: expStatus[aluPkg::statusI] = 1'b0;
          aluPkg::aluSetD: expStatus[aluPkg::statusD] = 1'b1;
          aluPkg::aluClrD: expStatus[aluPkg::statusD] = 1'b0;
          aluPkg::aluClrV: expStatus[aluPkg::statusV] = 1'b0;
          default: ;
        endcase
      end
    endcase
    if (hasResult) begin
      expStatus[aluPkg::statusN] = r[7];
      expStatus[aluPkg::statusZ] = (r == 8'h00);
    end
    if (writesReg) begin
      case (dst)
        dpBusPkg::dstAcc: expA = r;
        dpBusPkg::dstX:   expX = r;
        dpBusPkg::dstY:   expY = r;
        default: ;
      endcase
    end
  endtask

  // strobe one op, let the edge take it, then check everything
  task automatic doOp(input string testName, input dpBusPkg::busSrcT src,
                      input aluPkg::aluOpT alu, input dpBusPkg::regDstT dst,
                      input dpBusPkg::byteT data);
    opSrc    = src;
    opAlu    = alu;
    opDst    = dst;
    dataIn   = data;
    opStrobe = 1'b1;
    modelOp(src, alu, dst, data);
    @(posedge phi2);
    #1;
    opStrobe = 1'b0;
    checkAll(testName);
  endtask

  task automatic finishTest(input string testName);
    testCount++;
    $display("test %-10s done, %0d errors", testName, testErrors);
    testErrors = 0;
  endtask

  task automatic testReset();
    // zero registers, status 0x24
    expA = 8'h00;
    expX = 8'h00;
    expY = 8'h00;
    expStatus = 8'h24;
    checkAll("reset");
    finishTest("reset");
  endtask

  task automatic testLoads();
    doOp("loads", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstAcc, 8'h00);
    doOp("loads", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstX, 8'h80);
    doOp("loads", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstY, randomByte());
    doOp("loads", dpBusPkg::srcAcc, aluPkg::aluPass, dpBusPkg::dstX, randomByte());
    doOp("loads", dpBusPkg::srcX, aluPkg::aluPass, dpBusPkg::dstY, randomByte());
    doOp("loads", dpBusPkg::srcY, aluPkg::aluPass, dpBusPkg::dstAcc, randomByte());
    repeat (30) begin
      doOp("loads", dpBusPkg::busSrcT'($urandom_range(0, 3)), aluPkg::aluPass,
           dpBusPkg::regDstT'($urandom_range(1, 3)), randomByte());
    end
    finishTest("loads");
  endtask

  task automatic adcCase(input logic carry, input dpBusPkg::byteT a, input dpBusPkg::byteT b);
    doOp("adc", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstAcc, a);
    doOp("adc", dpBusPkg::srcData, carry ? aluPkg::aluSetC : aluPkg::aluClrC,
         dpBusPkg::dstNone, 8'h00);
    doOp("adc", dpBusPkg::srcAcc, aluPkg::aluAdc, dpBusPkg::dstAcc, b);
  endtask

  task automatic testAdc();
    // overflow both ways, carry out, carry-in into sign
    adcCase(1'b0, 8'h50, 8'h50);
    adcCase(1'b0, 8'hd0, 8'h90);
    adcCase(1'b1, 8'hff, 8'h00);
    adcCase(1'b1, 8'h7f, 8'h00);
    adcCase(1'b0, 8'h80, 8'h80);
    repeat (80) begin
      adcCase(1'($urandom_range(0, 1)), randomByte(), randomByte());
    end
    // chained add in X with the carry left by the last one
    doOp("adc", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstX, randomByte());
    repeat (10) begin
      doOp("adc", dpBusPkg::srcX, aluPkg::aluAdc, dpBusPkg::dstX, randomByte());
    end
    finishTest("adc");
  endtask

  task automatic testLogic();
    aluPkg::aluOpT ops[4];
    ops[0] = aluPkg::aluAnd;
    ops[1] = aluPkg::aluEor;
    ops[2] = aluPkg::aluOr;
    ops[3] = aluPkg::aluLsr;
    // V set first so untouched V is visible
    adcCase(1'b0, 8'h40, 8'h40);
    repeat (40) begin
      doOp("logic", dpBusPkg::srcData,
           $urandom_range(0, 1) ? aluPkg::aluSetC : aluPkg::aluClrC,
           dpBusPkg::dstNone, 8'h00);
      doOp("logic", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstAcc, randomByte());
      doOp("logic", dpBusPkg::srcAcc, ops[$urandom_range(0, 3)],
           dpBusPkg::regDstT'($urandom_range(1, 3)), randomByte());
    end
    finishTest("logic");
  endtask

  task automatic testCmpFlags();
    doOp("cmpFlags", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstAcc, 8'h42);
    doOp("cmpFlags", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstX, 8'h90);
    doOp("cmpFlags", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstY, 8'h05);
    doOp("cmpFlags", dpBusPkg::srcAcc, aluPkg::aluCmp, dpBusPkg::dstNone, 8'h42);
    doOp("cmpFlags", dpBusPkg::srcX, aluPkg::aluCmp, dpBusPkg::dstNone, 8'h10);
    doOp("cmpFlags", dpBusPkg::srcY, aluPkg::aluCmp, dpBusPkg::dstNone, 8'h06);
    repeat (30) begin
      doOp("cmpFlags", dpBusPkg::srcData, aluPkg::aluPass, dpBusPkg::dstX, randomByte());
      doOp("cmpFlags", dpBusPkg::srcX, aluPkg::aluCmp, dpBusPkg::dstNone, randomByte());
    end
    doOp("cmpFlags", dpBusPkg::srcAcc, aluPkg::aluSetC, dpBusPkg::dstNone, 8'h00);
    doOp("cmpFlags", dpBusPkg::srcAcc, aluPkg::aluClrC, dpBusPkg::dstNone, 8'h00);
    doOp("cmpFlags", dpBusPkg::srcAcc, aluPkg::aluClrI, dpBusPkg::dstNone, 8'h00);
    doOp("cmpFlags", dpBusPkg::srcAcc, aluPkg::aluSetI, dpBusPkg::dstNone, 8'h00);
    doOp("cmpFlags", dpBusPkg::srcAcc, aluPkg::aluSetD, dpBusPkg::dstNone, 8'h00);
    doOp("cmpFlags", dpBusPkg::srcAcc, aluPkg::aluClrD, dpBusPkg::dstNone, 8'h00);
    adcCase(1'b0, 8'h60, 8'h60);
    doOp("cmpFlags", dpBusPkg::srcAcc, aluPkg::aluClrV, dpBusPkg::dstNone, 8'h00);
    finishTest("cmpFlags");
  endtask

  // live op fields with the strobe low, nothing may change
  task automatic testIdle();
    repeat (8) begin
      opSrc    = dpBusPkg::srcData;
      opAlu    = aluPkg::aluOpT'($urandom_range(0, 13));
      opDst    = dpBusPkg::regDstT'($urandom_range(1, 3));
      dataIn   = randomByte();
      opStrobe = 1'b0;
      @(posedge phi2);
      #1;
      checkAll("idle");
    end
    finishTest("idle");
  endtask

  initial begin
    void'($urandom(32'h49d4));
    cycleCount = 0;
    checkCount = 0;
    errorCount = 0;
    testErrors = 0;
    testCount  = 0;
    arstN    = 1'b0;
    opStrobe = 1'b0;
    opSrc    = dpBusPkg::srcAcc;
    opAlu    = aluPkg::aluPass;
    opDst    = dpBusPkg::dstNone;
    dataIn   = 8'h00;
    repeat (3) @(posedge phi2);
    #1;
    arstN = 1'b1;
    testReset();
    testLoads();
    testAdc();
    testLogic();
    testCmpFlags();
    testIdle();
    errorCount += dut_i.cpuDatapath_sva_i.assertFails;
    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- tb/cpuDatapath_sva.sv
//////////////////////////////
// datapath assertions
// fixed status bits, register hold
//////////////////////////////
module cpuDatapath_sva (
  input logic             phi2,
  input logic             arstN,
  input logic             opStrobe,
  input dpBusPkg::regDstT opDst,
  input dpBusPkg::byteT   acc,
  input dpBusPkg::byteT   xReg,
  input dpBusPkg::byteT   yReg,
  input aluPkg::statusT   status
);
  timeunit 1ns;
  timeprecision 100ps;

  // count of failed assertions
  int assertFails = 0;

  fixedBits: assert property (@(posedge phi2) disable iff (!arstN)
    status[aluPkg::statusOne] == 1'b1 && status[aluPkg::statusB] == 1'b0)
    else begin
      $error("status bit 5 or bit 4 has the wrong value");
      assertFails++;
    end

  // no strobe, no register change
  holdIdle: assert property (@(posedge phi2) disable iff (!arstN)
    !opStrobe |=> $stable(acc) && $stable(xReg) && $stable(yReg))
    else begin
      $error("register changed on an edge without a strobe");
      assertFails++;
    end

  holdNoDst: assert property (@(posedge phi2) disable iff (!arstN)
    opStrobe && opDst == dpBusPkg::dstNone |=> $stable(acc) && $stable(xReg) && $stable(yReg))
    else begin
      $error("register changed on a strobe with no destination");
      assertFails++;
    end

endmodule

bind cpuDatapath cpuDatapath_sva cpuDatapath_sva_i (
  .phi2     (phi2),
  .arstN    (arstN),
  .opStrobe (opStrobe),
  .opDst    (opDst),
  .acc      (acc),
  .xReg     (xReg),
  .yReg     (yReg),
  .status   (status)
);

//--- hdl/cpuDatapath.sv
//////////////////////////////
// 6502 datapath top
// registers, ALU and status, one micro-op per strobe
//////////////////////////////
module cpuDatapath (
  input  logic             phi2,
  input  logic             arstN,
  input  logic             opStrobe,
  input  dpBusPkg::busSrcT opSrc,
  input  aluPkg::aluOpT    opAlu,
  input  dpBusPkg::regDstT opDst,
  input  dpBusPkg::byteT   dataIn,
  output dpBusPkg::byteT   acc,
  output dpBusPkg::byteT   xReg,
  output dpBusPkg::byteT   yReg,
  output aluPkg::statusT   status
);

  dpBusPkg::byteT specialBus;
  dpBusPkg::byteT result;
  logic           flagN;
  logic           flagZ;
  logic           flagC;
  logic           flagV;
  logic           carryFlag;

  registerBank registerBank_i (
    .phi2       (phi2),
    .arstN      (arstN),
    .opStrobe   (opStrobe),
    .opSrc      (opSrc),
    .opDst      (opDst),
    .dataIn     (dataIn),
    .result     (result),
    .specialBus (specialBus),
    .acc        (acc),
    .xReg       (xReg),
    .yReg       (yReg)
  );

  // operand B is always the strobed data byte
  aluCore aluCore_i (
    .opAlu    (opAlu),
    .operandA (specialBus),
    .operandB (dataIn),
    .carryIn  (carryFlag),
    .result   (result),
    .flagN    (flagN),
    .flagZ    (flagZ),
    .flagC    (flagC),
    .flagV    (flagV)
  );

  processorStatus processorStatus_i (
    .phi2      (phi2),
    .arstN     (arstN),
    .opStrobe  (opStrobe),
    .opAlu     (opAlu),
    .flagN     (flagN),
    .flagZ     (flagZ),
    .flagC     (flagC),
    .flagV     (flagV),
    .status    (status),
    .carryFlag (carryFlag)
  );

endmodule

//--- hdl/processorStatus.sv
//////////////////////////////
// processor status register
//////////////////////////////
module processorStatus (
  input  logic          phi2,
  input  logic          arstN,
  input  logic          opStrobe,
  input  aluPkg::aluOpT opAlu,
  input  logic          flagN,
  input  logic          flagZ,
  input  logic          flagC,
  input  logic          flagV,
  output aluPkg::statusT status,
  output logic          carryFlag
);

  logic nQ;
  logic vQ;
  logic dQ;
  logic iQ;
  logic zQ;
  logic cQ;

  always_ff @(posedge phi2 or negedge arstN) begin
    if (!arstN) begin
      nQ <= aluPkg::statusResetVal[aluPkg::statusN];
      vQ <= aluPkg::statusResetVal[aluPkg::statusV];
      dQ <= aluPkg::statusResetVal[aluPkg::statusD];
      iQ <= aluPkg::statusResetVal[aluPkg::statusI];
      zQ <= aluPkg::statusResetVal[aluPkg::statusZ];
      cQ <= aluPkg::statusResetVal[aluPkg::statusC];
    end else if (opStrobe) begin
      case (opAlu)
        aluPkg::aluPass, aluPkg::aluAnd, aluPkg::aluEor, aluPkg::aluOr: begin
          nQ <= flagN;
          zQ <= flagZ;
        end
        aluPkg::aluAdc: begin
          nQ <= flagN;
          zQ <= flagZ;
          cQ <= flagC;
          vQ <= flagV;
        end
        aluPkg::aluLsr, aluPkg::aluCmp: begin
          nQ <= flagN;
          zQ <= flagZ;
          cQ <= flagC;
        end
        aluPkg::aluSetC: cQ <= 1'b1;
        aluPkg::aluClrC: cQ <= 1'b0;
        aluPkg::aluSetI: iQ <= 1'b1;
        aluPkg::aluClrI: iQ <= 1'b0;
        aluPkg::aluSetD: dQ <= 1'b1;
        aluPkg::aluClrD: dQ <= 1'b0;
        aluPkg::aluClrV: vQ <= 1'b0;
        default: ;
      endcase
    end
  end

  // bit 5 tied high, B bit reads 0
  always_comb begin
    status                    = '0;
    status[aluPkg::statusN]   = nQ;
    status[aluPkg::statusV]   = vQ;
    status[aluPkg::statusOne] = 1'b1;
    status[aluPkg::statusB]   = 1'b0;
    status[aluPkg::statusD]   = dQ;
    status[aluPkg::statusI]   = iQ;
    status[aluPkg::statusZ]   = zQ;
    status[aluPkg::statusC]   = cQ;
  end

  assign carryFlag = cQ;

endmodule

//--- hdl/aluCore.sv
//////////////////////////////
// combinational ALU
// result byte plus candidate N, Z, C and V
//////////////////////////////
module aluCore (
  input  aluPkg::aluOpT  opAlu,
  input  dpBusPkg::byteT operandA,
  input  dpBusPkg::byteT operandB,
  input  logic           carryIn,
  output dpBusPkg::byteT result,
  output logic           flagN,
  output logic           flagZ,
  output logic           flagC,
  output logic           flagV
);

  localparam int msb = dpBusPkg::byteWidth - 1;

  // one extra bit holds carry out or borrow
  logic [dpBusPkg::byteWidth:0] sum;
  logic [dpBusPkg::byteWidth:0] diff;
  logic                         sumOverflow;

  assign sum  = {1'b0, operandA} + {1'b0, operandB} + {{dpBusPkg::byteWidth{1'b0}}, carryIn};
  assign diff = {1'b0, operandA} - {1'b0, operandB};

  // same operand signs but the sum sign flipped
  assign sumOverflow = (operandA[msb] == operandB[msb]) && (sum[msb] != operandA[msb]);

  always_comb begin
    result = operandA;
    flagC  = 1'b0;
    flagV  = 1'b0;
    case (opAlu)
      aluPkg::aluPass: begin
        result = operandA;
      end
      aluPkg::aluAdc: begin
        result = sum[msb:0];
        flagC  = sum[dpBusPkg::byteWidth];
        flagV  = sumOverflow;
      end
      aluPkg::aluAnd: begin
        result = operandA & operandB;
      end
      aluPkg::aluEor: begin
        result = operandA ^ operandB;
      end
      aluPkg::aluOr: begin
        result = operandA | operandB;
      end
      aluPkg::aluLsr: begin
        // zero shifted into the top bit
        result = {1'b0, operandA[msb:1]};
        flagC  = operandA[0];
      end
      aluPkg::aluCmp: begin
        // no borrow means A is at least B
        result = diff[msb:0];
        flagC  = ~diff[dpBusPkg::byteWidth];
      end
      default: begin
        // flag operations leave A on the result
        result = operandA;
      end
    endcase
  end

  assign flagN = result[msb];
  assign flagZ = (result == '0);

endmodule

//--- hdl/registerBank.sv
//////////////////////////////
// programmer registers A, X and Y
// special bus read mux and result write decode
//////////////////////////////
module registerBank (
  input  logic             phi2,
  input  logic             arstN,
  input  logic             opStrobe,
  input  dpBusPkg::busSrcT opSrc,
  input  dpBusPkg::regDstT opDst,
  input  dpBusPkg::byteT   dataIn,
  input  dpBusPkg::byteT   result,
  output dpBusPkg::byteT   specialBus,
  output dpBusPkg::byteT   acc,
  output dpBusPkg::byteT   xReg,
  output dpBusPkg::byteT   yReg
);

  dpBusPkg::byteT accQ;
  dpBusPkg::byteT xQ;
  dpBusPkg::byteT yQ;

  logic wrAcc;
  logic wrX;
  logic wrY;

  // exactly one source per micro-operation
  always_comb begin
    case (opSrc)
      dpBusPkg::srcAcc: specialBus = accQ;
      dpBusPkg::srcX:   specialBus = xQ;
      dpBusPkg::srcY:   specialBus = yQ;
      default:          specialBus = dataIn;
    endcase
  end

  // write decode, nothing written for dstNone
  assign wrAcc = opStrobe && (opDst == dpBusPkg::dstAcc);
  assign wrX   = opStrobe && (opDst == dpBusPkg::dstX);
  assign wrY   = opStrobe && (opDst == dpBusPkg::dstY);

  always_ff @(posedge phi2 or negedge arstN) begin
    if (!arstN) begin
      accQ <= dpBusPkg::regResetVal;
      xQ   <= dpBusPkg::regResetVal;
      yQ   <= dpBusPkg::regResetVal;
    end else begin
      if (wrAcc) begin
        accQ <= result;
      end
      if (wrX) begin
        xQ <= result;
      end
      if (wrY) begin
        yQ <= result;
      end
    end
  end

  assign acc  = accQ;
  assign xReg = xQ;
  assign yReg = yQ;

endmodule

//--- hdl/aluPkg.sv
//////////////////////////////
// ALU and status package
// function codes and processor status layout
//////////////////////////////
package aluPkg;

  // result functions first, then the flag-only operations
  typedef enum logic [3:0] {
    aluPass = 4'd0,
    aluAdc  = 4'd1,
    aluAnd  = 4'd2,
    aluEor  = 4'd3,
    aluOr   = 4'd4,
    aluLsr  = 4'd5,
    aluCmp  = 4'd6,
    aluSetC = 4'd7,
    aluClrC = 4'd8,
    aluSetI = 4'd9,
    aluClrI = 4'd10,
    aluSetD = 4'd11,
    aluClrD = 4'd12,
    aluClrV = 4'd13
  } aluOpT;

  typedef logic [7:0] statusT;

  // bit positions in the status word, NV1BDIZC
  localparam int statusN   = 7;
  localparam int statusV   = 6;
  localparam int statusOne = 5;
  localparam int statusB   = 4;
  localparam int statusD   = 3;
  localparam int statusI   = 2;
  localparam int statusZ   = 1;
  localparam int statusC   = 0;

  // constant one bit and interrupt disable set
  localparam statusT statusResetVal = 8'h24;

endpackage

//--- hdl/dpBusPkg.sv
//////////////////////////////
// datapath bus package
// byte type, special bus sources and register destinations
//////////////////////////////
package dpBusPkg;

  // width of every datapath byte
  localparam int byteWidth = 8;

  typedef logic [byteWidth-1:0] byteT;

  // who drives the special bus for one micro-operation
  typedef enum logic [1:0] {
    srcAcc  = 2'd0,
    srcX    = 2'd1,
    srcY    = 2'd2,
    srcData = 2'd3
  } busSrcT;

  // register written from the ALU result
  typedef enum logic [1:0] {
    dstNone = 2'd0,
    dstAcc  = 2'd1,
    dstX    = 2'd2,
    dstY    = 2'd3
  } regDstT;

  // A, X and Y after reset
  localparam byteT regResetVal = '0;

endpackage
